// File: sources.f
hdl/rv_isa_pkg.sv
hdl/lsu_mem_pkg.sv
hdl/lsu_addr_stage.sv
hdl/lsu_mem_stage.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
sim/lsu_assertions.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sources.f --top-module lsu_tb -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/lsu_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: sim/lsu_tb.sv
module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_words = 256;
    localparam int reset_cycles = 3;
    localparam int latency = 3;
    localparam int margin = 10;

    // major opcodes as the ISA defines them.
    localparam rv_isa_pkg::opcode_t op_load  = 7'b0000011;
    localparam rv_isa_pkg::opcode_t op_store = 7'b0100011;
    localparam rv_isa_pkg::opcode_t op_imm   = 7'b0010011;
    localparam rv_isa_pkg::opcode_t op_lui   = 7'b0110111;

    typedef struct {
        rv_isa_pkg::inst_t    inst;
        lsu_mem_pkg::word_t   rs1;
        lsu_mem_pkg::word_t   rs2;
        logic                 valid;
        logic                 is_load;
        logic                 fault;
        rv_isa_pkg::reg_idx_t rd;
        lsu_mem_pkg::word_t   data;
    } row_t;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 in_valid;
    rv_isa_pkg::inst_t    in_inst;
    lsu_mem_pkg::word_t   in_rs1;
    lsu_mem_pkg::word_t   in_rs2;
    logic                 out_valid;
    rv_isa_pkg::reg_idx_t out_rd;
    logic                 out_is_load;
    logic                 out_fault;
    lsu_mem_pkg::word_t   out_load_data;
    logic                 exp_valid;
    logic                 exp_is_load;
    logic                 exp_fault;
    rv_isa_pkg::reg_idx_t exp_rd;
    lsu_mem_pkg::word_t   exp_data;
    int                   check_errors;
    int                   checked;
    row_t                 rows [$];
    int                   n_rows = 0;
    int                   cycles = 0;
    int                   total_errors;
    logic                 timed_out = 1'b0;

    always #10 clk = ~clk;

    lsu_top #(
        .MEM_WORDS (mem_words)
    ) i_lsu_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_inst       (in_inst),
        .in_rs1        (in_rs1),
        .in_rs2        (in_rs2),
        .out_valid     (out_valid),
        .out_rd        (out_rd),
        .out_is_load   (out_is_load),
        .out_fault     (out_fault),
        .out_load_data (out_load_data)
    );

    lsu_checker i_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .exp_valid     (exp_valid),
        .exp_is_load   (exp_is_load),
        .exp_fault     (exp_fault),
        .exp_rd        (exp_rd),
        .exp_data      (exp_data),
        .out_valid     (out_valid),
        .out_rd        (out_rd),
        .out_is_load   (out_is_load),
        .out_fault     (out_fault),
        .out_load_data (out_load_data),
        .errors        (check_errors),
        .checked       (checked)
    );

    bind lsu_top lsu_assertions i_assertions (
        .clk           (clk),
        .rst_n         (rst_n),
        .out_valid     (out_valid),
        .out_is_load   (out_is_load),
        .out_fault     (out_fault),
        .out_load_data (out_load_data)
    );

    function automatic rv_isa_pkg::inst_t make_inst(rv_isa_pkg::opcode_t op, logic [2:0] f3,
                                                    rv_isa_pkg::reg_idx_t rd, logic [11:0] imm);
        // S-type splits the immediate around rs2 and rs1.
        if (op == op_store) begin
            return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], op};
        end else begin
            return {imm, 5'd1, f3, rd, op};
        end
    endfunction

    task automatic add_store(logic [2:0] f3, logic [11:0] imm, lsu_mem_pkg::word_t rs1,
                             lsu_mem_pkg::word_t rs2, logic fault);
        rows.push_back(row_t'{make_inst(op_store, f3, 5'd0, imm), rs1, rs2,
                              1'b1, 1'b0, fault, 5'd0, 32'd0});
    endtask

    task automatic add_load(logic [2:0] f3, rv_isa_pkg::reg_idx_t rd, logic [11:0] imm,
                            lsu_mem_pkg::word_t rs1, logic fault, lsu_mem_pkg::word_t data);
        rows.push_back(row_t'{make_inst(op_load, f3, rd, imm), rs1, 32'd0,
                              1'b1, 1'b1, fault, rd, data});
    endtask

    task automatic add_other(rv_isa_pkg::opcode_t op, rv_isa_pkg::reg_idx_t rd);
        rows.push_back(row_t'{make_inst(op, 3'd0, rd, 12'h001), 32'h100, 32'd0,
                              1'b0, 1'b0, 1'b0, rd, 32'd0});
    endtask

    task automatic build_table();
        // word store with a load right behind it.
        add_store(3'd2, 12'h000, 32'h0000_0100, 32'hdead_beef, 1'b0);
        add_load(3'd2, 5'd5, 12'h010, 32'h0000_00f0, 1'b0, 32'hdead_beef);
        add_store(3'd2, 12'h004, 32'h0000_0100, 32'h1234_5678, 1'b0);
        add_load(3'd2, 5'd6, 12'h000, 32'h0000_0104, 1'b0, 32'h1234_5678);
        // byte lanes of word 0x108.
        add_store(3'd2, 12'h000, 32'h0000_0108, 32'h1122_3344, 1'b0);
        add_store(3'd0, 12'h000, 32'h0000_0108, 32'haaaa_aa81, 1'b0);
        add_load(3'd2, 5'd7, 12'h000, 32'h0000_0108, 1'b0, 32'h1122_3381);
        add_store(3'd0, 12'h001, 32'h0000_0108, 32'h5555_557f, 1'b0);
        add_store(3'd0, 12'h002, 32'h0000_0108, 32'h0000_00c3, 1'b0);
        add_store(3'd0, 12'h003, 32'h0000_0108, 32'hffff_ff24, 1'b0);
        add_load(3'd2, 5'd8, 12'h000, 32'h0000_0108, 1'b0, 32'h24c3_7f81);
        add_load(3'd0, 5'd9, 12'h000, 32'h0000_0108, 1'b0, 32'hffff_ff81);
        add_load(3'd4, 5'd10, 12'h000, 32'h0000_0108, 1'b0, 32'h0000_0081);
        add_load(3'd0, 5'd11, 12'h001, 32'h0000_0108, 1'b0, 32'h0000_007f);
        add_load(3'd4, 5'd12, 12'h001, 32'h0000_0108, 1'b0, 32'h0000_007f);
        add_load(3'd0, 5'd13, 12'h002, 32'h0000_0108, 1'b0, 32'hffff_ffc3);
        add_load(3'd4, 5'd14, 12'h002, 32'h0000_0108, 1'b0, 32'h0000_00c3);
        add_load(3'd0, 5'd15, 12'h003, 32'h0000_0108, 1'b0, 32'h0000_0024);
        add_load(3'd4, 5'd16, 12'h003, 32'h0000_0108, 1'b0, 32'h0000_0024);
        // upper half first, then the lower half through a negative offset.
        add_store(3'd1, 12'h002, 32'h0000_0110, 32'h0000_8001, 1'b0);
        add_store(3'd1, 12'hff0, 32'h0000_0120, 32'habcd_7ffe, 1'b0);
        add_load(3'd2, 5'd17, 12'h000, 32'h0000_0110, 1'b0, 32'h8001_7ffe);
        add_load(3'd1, 5'd18, 12'hff8, 32'h0000_0118, 1'b0, 32'h0000_7ffe);
        add_load(3'd5, 5'd19, 12'hff8, 32'h0000_0118, 1'b0, 32'h0000_7ffe);
        add_load(3'd1, 5'd20, 12'hffa, 32'h0000_0118, 1'b0, 32'hffff_8001);
        add_load(3'd5, 5'd21, 12'hffa, 32'h0000_0118, 1'b0, 32'h0000_8001);
        // misaligned and unsupported accesses.
        add_store(3'd2, 12'h001, 32'h0000_0100, 32'hffff_ffff, 1'b1);
        add_store(3'd1, 12'h001, 32'h0000_0100, 32'hffff_ffff, 1'b1);
        add_store(3'd1, 12'h003, 32'h0000_0100, 32'hffff_ffff, 1'b1);
        add_store(3'd3, 12'h000, 32'h0000_0100, 32'h0000_0000, 1'b1);
        add_store(3'd4, 12'h000, 32'h0000_0100, 32'h0000_0000, 1'b1);
        add_load(3'd2, 5'd22, 12'h002, 32'h0000_0100, 1'b1, 32'h0000_0000);
        add_load(3'd1, 5'd23, 12'h001, 32'h0000_0100, 1'b1, 32'h0000_0000);
        add_load(3'd5, 5'd24, 12'h003, 32'h0000_0100, 1'b1, 32'h0000_0000);
        add_load(3'd3, 5'd25, 12'h000, 32'h0000_0100, 1'b1, 32'h0000_0000);
        add_load(3'd6, 5'd26, 12'h000, 32'h0000_0100, 1'b1, 32'h0000_0000);
        add_load(3'd2, 5'd27, 12'h000, 32'h0000_0100, 1'b0, 32'hdead_beef);
        // non-memory opcodes give no result.
        add_other(op_imm, 5'd28);
        add_load(3'd2, 5'd29, 12'h000, 32'h0000_0104, 1'b0, 32'h1234_5678);
        add_other(op_lui, 5'd30);
        add_load(3'd2, 5'd31, 12'h004, 32'h0000_0104, 1'b0, 32'h24c3_7f81);
        // addresses past the memory depth wrap.
        add_store(3'd2, 12'h000, 32'h0000_0500, 32'hcafe_f00d, 1'b0);
        add_load(3'd2, 5'd2, 12'h000, 32'h0000_0100, 1'b0, 32'hcafe_f00d);
        add_load(3'd0, 5'd3, 12'h001, 32'h0000_4100, 1'b0, 32'hffff_fff0);
        add_load(3'd4, 5'd4, 12'h001, 32'h0000_4100, 1'b0, 32'h0000_00f0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= reset_cycles + n_rows + latency + margin) begin
            timed_out <= 1'b1;
        end
    end

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_inst = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        exp_valid = 1'b0;
        exp_is_load = 1'b0;
        exp_fault = 1'b0;
        exp_rd = '0;
        exp_data = '0;
        build_table();
        n_rows = rows.size();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        foreach (rows[i]) begin
            in_valid    <= 1'b1;
            in_inst     <= rows[i].inst;
            in_rs1      <= rows[i].rs1;
            in_rs2      <= rows[i].rs2;
            exp_valid   <= rows[i].valid;
            exp_is_load <= rows[i].is_load;
            exp_fault   <= rows[i].fault;
            exp_rd      <= rows[i].rd;
            exp_data    <= rows[i].data;
            @(posedge clk);
        end
        in_valid  <= 1'b0;
        exp_valid <= 1'b0;
        wait (checked == n_rows || timed_out);
        if (timed_out) begin
            $display("Timeout: only %0d of %0d rows were checked before the cycle limit",
                     checked, n_rows);
        end
        total_errors = check_errors + int'(i_lsu_top.i_assertions.fail_count) + int'(timed_out);
        $display("Errors: %0d (mismatches %0d, assertion failures %0d, timeouts %0d)",
                 total_errors, check_errors, i_lsu_top.i_assertions.fail_count, timed_out);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sim/lsu_checker.sv
module lsu_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic                 exp_valid,
    input  logic                 exp_is_load,
    input  logic                 exp_fault,
    input  rv_isa_pkg::reg_idx_t exp_rd,
    input  lsu_mem_pkg::word_t   exp_data,
    input  logic                 out_valid,
    input  rv_isa_pkg::reg_idx_t out_rd,
    input  logic                 out_is_load,
    input  logic                 out_fault,
    input  lsu_mem_pkg::word_t   out_load_data,
    output int                   errors,
    output int                   checked
);
    timeunit 1ns;
    timeprecision 100ps;

    // expected results, three edges deep.
    logic [2:0]           tag_q;
    logic [2:0]           valid_q;
    logic [2:0]           load_q;
    logic [2:0]           fault_q;
    rv_isa_pkg::reg_idx_t rd_q [3];
    lsu_mem_pkg::word_t   data_q [3];
    int                   err_count = 0;
    int                   seen = 0;

    assign errors = err_count;
    assign checked = seen;

    task automatic report_mismatch(string field, lsu_mem_pkg::word_t got,
                                   lsu_mem_pkg::word_t want);
        err_count = err_count + 1;
        $display("[ERROR] %0d ns: %s is 0x%08h, expected 0x%08h", $time, field, got, want);
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            tag_q   <= '0;
            valid_q <= '0;
        end else begin
            tag_q   <= {tag_q[1:0], in_valid};
            valid_q <= {valid_q[1:0], in_valid && exp_valid};
        end
        load_q    <= {load_q[1:0], exp_is_load};
        fault_q   <= {fault_q[1:0], exp_fault};
        rd_q[0]   <= exp_rd;
        rd_q[1]   <= rd_q[0];
        rd_q[2]   <= rd_q[1];
        data_q[0] <= exp_data;
        data_q[1] <= data_q[0];
        data_q[2] <= data_q[1];
    end

    // outputs are settled mid-cycle.
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid !== valid_q[2]) begin
                report_mismatch("out_valid", 32'(out_valid), 32'(valid_q[2]));
            end
            if (valid_q[2]) begin
                if (out_is_load !== load_q[2]) begin
                    report_mismatch("out_is_load", 32'(out_is_load), 32'(load_q[2]));
                end
                if (out_fault !== fault_q[2]) begin
                    report_mismatch("out_fault", 32'(out_fault), 32'(fault_q[2]));
                end
                if (out_load_data !== data_q[2]) begin
                    report_mismatch("out_load_data", out_load_data, data_q[2]);
                end
                if (load_q[2] && (out_rd !== rd_q[2])) begin
                    report_mismatch("out_rd", 32'(out_rd), 32'(rd_q[2]));
                end
            end
            if (tag_q[2]) begin
                seen = seen + 1;
            end
        end
    end

endmodule

// File: sim/lsu_assertions.sv
module lsu_assertions (
    input logic               clk,
    input logic               rst_n,
    input logic               out_valid,
    input logic               out_is_load,
    input logic               out_fault,
    input lsu_mem_pkg::word_t out_load_data
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned idle_fails = 0;
    int unsigned data_fails = 0;
    int unsigned fault_fails = 0;
    logic [31:0] fail_count;

    assign fail_count = idle_fails + data_fails + fault_fails;

    // pipe is empty right after a reset edge.
    idle_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            idle_fails = idle_fails + 1;
            $error("out_valid was high in the cycle after reset");
        end

    no_data_without_load: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && (out_fault || !out_is_load)) |-> (out_load_data == '0))
        else begin
            data_fails = data_fails + 1;
            $error("out_load_data was nonzero on a store or a faulting access");
        end

    fault_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_fault |-> out_valid)
        else begin
            fault_fails = fault_fails + 1;
            $error("out_fault was set while out_valid was low");
        end

endmodule

// File: hdl/lsu_top.sv
module lsu_top #(
    parameter int MEM_WORDS = lsu_mem_pkg::mem_words_default
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  rv_isa_pkg::inst_t    in_inst,
    input  lsu_mem_pkg::word_t   in_rs1,
    input  lsu_mem_pkg::word_t   in_rs2,
    output logic                 out_valid,
    output rv_isa_pkg::reg_idx_t out_rd,
    output logic                 out_is_load,
    output logic                 out_fault,
    output lsu_mem_pkg::word_t   out_load_data
);

    // address stage to memory stage.
    logic                   s1_valid;
    rv_isa_pkg::mem_op_e    s1_op;
    logic [2:0]             s1_funct3;
    rv_isa_pkg::reg_idx_t   s1_rd;
    lsu_mem_pkg::addr_t     s1_addr;
    lsu_mem_pkg::word_t     s1_wdata;

    // memory stage to align stage.
    logic                   s2_valid;
    rv_isa_pkg::mem_op_e    s2_op;
    logic [2:0]             s2_funct3;
    rv_isa_pkg::reg_idx_t   s2_rd;
    lsu_mem_pkg::lane_off_t s2_lane_off;
    logic                   s2_fault;
    lsu_mem_pkg::word_t     s2_rdata;

    lsu_addr_stage i_addr_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .s1_valid  (s1_valid),
        .s1_op     (s1_op),
        .s1_funct3 (s1_funct3),
        .s1_rd     (s1_rd),
        .s1_addr   (s1_addr),
        .s1_wdata  (s1_wdata)
    );

    lsu_mem_stage #(
        .MEM_WORDS (MEM_WORDS)
    ) i_mem_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .s1_valid    (s1_valid),
        .s1_op       (s1_op),
        .s1_funct3   (s1_funct3),
        .s1_rd       (s1_rd),
        .s1_addr     (s1_addr),
        .s1_wdata    (s1_wdata),
        .s2_valid    (s2_valid),
        .s2_op       (s2_op),
        .s2_funct3   (s2_funct3),
        .s2_rd       (s2_rd),
        .s2_lane_off (s2_lane_off),
        .s2_fault    (s2_fault),
        .s2_rdata    (s2_rdata)
    );

    lsu_load_align i_load_align (
        .clk           (clk),
        .rst_n         (rst_n),
        .s2_valid      (s2_valid),
        .s2_op         (s2_op),
        .s2_funct3     (s2_funct3),
        .s2_rd         (s2_rd),
        .s2_lane_off   (s2_lane_off),
        .s2_fault      (s2_fault),
        .s2_rdata      (s2_rdata),
        .out_valid     (out_valid),
        .out_rd        (out_rd),
        .out_is_load   (out_is_load),
        .out_fault     (out_fault),
        .out_load_data (out_load_data)
    );

endmodule

// File: hdl/lsu_load_align.sv
module lsu_load_align (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   s2_valid,
    input  rv_isa_pkg::mem_op_e    s2_op,
    input  logic [2:0]             s2_funct3,
    input  rv_isa_pkg::reg_idx_t   s2_rd,
    input  lsu_mem_pkg::lane_off_t s2_lane_off,
    input  logic                   s2_fault,
    input  lsu_mem_pkg::word_t     s2_rdata,
    output logic                   out_valid,
    output rv_isa_pkg::reg_idx_t   out_rd,
    output logic                   out_is_load,
    output logic                   out_fault,
    output lsu_mem_pkg::word_t     out_load_data
);

    lsu_mem_pkg::word_t shifted;
    lsu_mem_pkg::word_t extended;
    logic               is_load;

    assign is_load = (s2_op == rv_isa_pkg::mem_load);
    // bring the addressed lane down to bit 0.
    assign shifted = s2_rdata >> {s2_lane_off, 3'b000};

    always_comb begin
        case (s2_funct3)
            rv_isa_pkg::f3_byte:  extended = {{24{shifted[7]}}, shifted[7:0]};
            rv_isa_pkg::f3_half:  extended = {{16{shifted[15]}}, shifted[15:0]};
            rv_isa_pkg::f3_word:  extended = shifted;
            rv_isa_pkg::f3_byteu: extended = {24'b0, shifted[7:0]};
            rv_isa_pkg::f3_halfu: extended = {16'b0, shifted[15:0]};
            default:              extended = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            out_is_load <= 1'b0;
            out_fault   <= 1'b0;
        end else begin
            out_valid   <= s2_valid;
            out_is_load <= s2_valid && is_load;
            out_fault   <= s2_fault;
        end
    end

    // stores and faults return zero.
    always_ff @(posedge clk) begin
        out_rd        <= s2_rd;
        out_load_data <= (is_load && !s2_fault) ? extended : '0;
    end

endmodule

// File: hdl/lsu_mem_stage.sv
module lsu_mem_stage #(
    parameter int MEM_WORDS = lsu_mem_pkg::mem_words_default
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   s1_valid,
    input  rv_isa_pkg::mem_op_e    s1_op,
    input  logic [2:0]             s1_funct3,
    input  rv_isa_pkg::reg_idx_t   s1_rd,
    input  lsu_mem_pkg::addr_t     s1_addr,
    input  lsu_mem_pkg::word_t     s1_wdata,
    output logic                   s2_valid,
    output rv_isa_pkg::mem_op_e    s2_op,
    output logic [2:0]             s2_funct3,
    output rv_isa_pkg::reg_idx_t   s2_rd,
    output lsu_mem_pkg::lane_off_t s2_lane_off,
    output logic                   s2_fault,
    output lsu_mem_pkg::word_t     s2_rdata
);

    localparam int idx_bits = $clog2(MEM_WORDS);

    lsu_mem_pkg::word_t         mem [MEM_WORDS];
    lsu_mem_pkg::lane_off_t     lane_off;
    logic [idx_bits-1:0]        word_idx;
    logic                       funct3_ok;
    logic                       misaligned;
    logic                       fault;
    lsu_mem_pkg::byte_mask_t    size_mask;
    lsu_mem_pkg::byte_mask_t    wmask;
    lsu_mem_pkg::word_t         wdata_sh;

    assign lane_off = s1_addr[1:0];
    // word index wraps modulo the memory depth.
    assign word_idx = s1_addr[2 +: idx_bits];

    // size decode; unsigned codes are legal for loads only.
    always_comb begin
        funct3_ok  = 1'b0;
        misaligned = 1'b0;
        size_mask  = '0;
        case (s1_funct3)
            rv_isa_pkg::f3_byte: begin
                funct3_ok = 1'b1;
                size_mask = 4'b0001;
            end
            rv_isa_pkg::f3_half: begin
                funct3_ok  = 1'b1;
                misaligned = lane_off[0];
                size_mask  = 4'b0011;
            end
            rv_isa_pkg::f3_word: begin
                funct3_ok  = 1'b1;
                misaligned = (lane_off != 2'd0);
                size_mask  = 4'b1111;
            end
            rv_isa_pkg::f3_byteu: begin
                funct3_ok = (s1_op == rv_isa_pkg::mem_load);
            end
            rv_isa_pkg::f3_halfu: begin
                funct3_ok  = (s1_op == rv_isa_pkg::mem_load);
                misaligned = lane_off[0];
            end
            default: begin
                funct3_ok = 1'b0;
            end
        endcase
    end

    assign fault = !funct3_ok || misaligned;

    // a faulting store enables no lanes.
    assign wmask = (s1_valid && (s1_op == rv_isa_pkg::mem_store) && !fault)
                   ? lsu_mem_pkg::byte_mask_t'(size_mask << lane_off) : '0;
    assign wdata_sh = s1_wdata << {lane_off, 3'b000};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wmask[i]) begin
                mem[word_idx][8*i +: 8] <= wdata_sh[8*i +: 8];
            end
        end
        if (s1_valid && (s1_op == rv_isa_pkg::mem_load)) begin
            s2_rdata <= mem[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
            s2_op    <= rv_isa_pkg::mem_none;
            s2_fault <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s2_op    <= s1_op;
            s2_fault <= s1_valid && fault;
        end
    end

    always_ff @(posedge clk) begin
        s2_funct3   <= s1_funct3;
        s2_rd       <= s1_rd;
        s2_lane_off <= lane_off;
    end

endmodule

// File: hdl/lsu_addr_stage.sv
module lsu_addr_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  rv_isa_pkg::inst_t    in_inst,
    input  lsu_mem_pkg::word_t   in_rs1,
    input  lsu_mem_pkg::word_t   in_rs2,
    output logic                 s1_valid,
    output rv_isa_pkg::mem_op_e  s1_op,
    output logic [2:0]           s1_funct3,
    output rv_isa_pkg::reg_idx_t s1_rd,
    output lsu_mem_pkg::addr_t   s1_addr,
    output lsu_mem_pkg::word_t   s1_wdata
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::mem_op_e op;
    lsu_mem_pkg::word_t  imm;

    assign opcode = in_inst[6:0];

    // decode and pick the immediate layout.
    always_comb begin
        case (opcode)
            rv_isa_pkg::opcode_load: begin
                op  = rv_isa_pkg::mem_load;
                imm = {{20{in_inst[31]}}, in_inst[31:20]};
            end
            rv_isa_pkg::opcode_store: begin
                op  = rv_isa_pkg::mem_store;
                imm = {{20{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
            end
            default: begin
                op  = rv_isa_pkg::mem_none;
                imm = '0;
            end
        endcase
    end

    // non-memory opcodes are dropped here.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_op    <= rv_isa_pkg::mem_none;
        end else begin
            s1_valid <= in_valid && (op != rv_isa_pkg::mem_none);
            s1_op    <= op;
        end
    end

    always_ff @(posedge clk) begin
        s1_funct3 <= in_inst[14:12];
        s1_rd     <= in_inst[11:7];
        s1_addr   <= in_rs1 + imm;
        s1_wdata  <= in_rs2;
    end

endmodule

// File: hdl/lsu_mem_pkg.sv
package lsu_mem_pkg;

    // data word and byte address.
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // one enable per byte lane of a word.
    typedef logic [3:0] byte_mask_t;

    // byte offset inside a word.
    typedef logic [1:0] lane_off_t;

    // data memory depth in words, power of two.
    localparam int mem_words_default = 256;

endpackage

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // raw instruction word and its fields.
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // major opcodes handled by the load/store unit.
    localparam opcode_t opcode_load  = 7'b0000011;
    localparam opcode_t opcode_store = 7'b0100011;

    // funct3 access size codes, shared by loads and stores.
    localparam logic [2:0] f3_byte  = 3'b000;
    localparam logic [2:0] f3_half  = 3'b001;
    localparam logic [2:0] f3_word  = 3'b010;
    // unsigned forms exist for loads only.
    localparam logic [2:0] f3_byteu = 3'b100;
    localparam logic [2:0] f3_halfu = 3'b101;

    // kind of memory access carried down the pipe.
    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

endpackage
